/* Makefile */
VERILATOR   ?= verilator
TOP         := param_load_tb
FILELIST    := param_load.f
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only -Wall --timing
OBJ_DIR     := obj_dir
LOG         := sim.log
FAIL_MSG    := Done: errors found
PASS_MSG    := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/param_load_config.svh */
`ifndef PARAM_LOAD_CONFIG_SVH
`define PARAM_LOAD_CONFIG_SVH

// stream word and table entry width
`define PL_DATA_W 64

// weight buffer address width
// 1024 words, one stream word per entry
`define PL_WEIGHT_ADDR_W 10

// per-channel table address width
// 64 entries each for bias, scale and shift
`define PL_CHAN_ADDR_W 6

// matching depths for the ram instances
`define PL_WEIGHT_DEPTH (1 << `PL_WEIGHT_ADDR_W)
`define PL_CHAN_DEPTH (1 << `PL_CHAN_ADDR_W)

`endif

/* param_load.f */
+incdir+include
rtl/param_load_pkg.sv
rtl/param_ram.sv
rtl/load_sequencer.sv
rtl/param_write_stage.sv
rtl/param_load_top.sv
test/param_load_tb.sv

/* rtl/load_sequencer.sv */
`timescale 1ns/1ps

module load_sequencer (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start,
   input  param_load_pkg::weight_count_t weight_len,
   input  param_load_pkg::chan_count_t   chan_len,
   input  logic                          s_valid,
   output logic                          s_ready,
   output logic                          done,
   output logic                          beat,
   output param_load_pkg::load_phase_e   phase,
   output param_load_pkg::weight_addr_t  index
);

   // lengths held for the whole load
   param_load_pkg::weight_count_t weight_len_q;
   param_load_pkg::chan_count_t   chan_len_q;

   // beats accepted in the current phase
   param_load_pkg::weight_addr_t  count;

   param_load_pkg::weight_count_t phase_len;
   param_load_pkg::weight_count_t count_inc;
   param_load_pkg::load_phase_e   next_phase;
   logic                          last_beat;

   // accepted beat, ready is already registered
   assign beat = s_valid & s_ready;
   assign index = count;

   // weight phase uses its own length, the tables share chan_len
   assign phase_len = (phase == param_load_pkg::PHASE_WEIGHT) ?
                      weight_len_q :
                      param_load_pkg::weight_count_t'(chan_len_q);

   // count + 1 in the wider type so len == 1024 still matches
   assign count_inc = param_load_pkg::weight_count_t'(count) +
                      param_load_pkg::weight_count_t'(1);
   assign last_beat = (count_inc == phase_len);

   // phase order after the last beat of a phase
   always_comb begin
      case (phase)
         param_load_pkg::PHASE_WEIGHT: next_phase = param_load_pkg::PHASE_BIAS;
         param_load_pkg::PHASE_BIAS:   next_phase = param_load_pkg::PHASE_SCALE;
         param_load_pkg::PHASE_SCALE:  next_phase = param_load_pkg::PHASE_SHIFT;
         default:                      next_phase = param_load_pkg::PHASE_IDLE;
      endcase
   end

   // length capture, only when a load is accepted
   always_ff @(posedge clk) begin
      if (rst) begin
         weight_len_q <= '0;
         chan_len_q <= '0;
      end else if (phase == param_load_pkg::PHASE_IDLE && start) begin
         weight_len_q <= weight_len;
         chan_len_q <= chan_len;
      end
   end

   // phase fsm and beat counter
   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= param_load_pkg::PHASE_IDLE;
         count <= '0;
      end else if (phase == param_load_pkg::PHASE_IDLE) begin
         count <= '0;
         if (start) begin
            phase <= param_load_pkg::PHASE_WEIGHT;
         end
      end else if (beat) begin
         if (last_beat) begin
            // counter restarts at each phase boundary
            count <= '0;
            phase <= next_phase;
         end else begin
            count <= count + 1'b1;
         end
      end
   end

   // ready up on start, down with the last shift beat
   // stays high across the inner phase changes
   always_ff @(posedge clk) begin
      if (rst) begin
         s_ready <= 1'b0;
      end else if (phase == param_load_pkg::PHASE_IDLE && start) begin
         s_ready <= 1'b1;
      end else if (phase == param_load_pkg::PHASE_SHIFT && beat && last_beat) begin
         s_ready <= 1'b0;
      end
   end

   // single cycle completion pulse
   always_ff @(posedge clk) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= (phase == param_load_pkg::PHASE_SHIFT) && beat && last_beat;
      end
   end

   // no beat can be taken outside a load
   a_ready_idle : assert property (@(posedge clk) disable iff (rst)
      (phase == param_load_pkg::PHASE_IDLE) |-> !s_ready);

   // one pulse per load
   a_done_pulse : assert property (@(posedge clk) disable iff (rst)
      done |=> !done);

   // zero length would wrap the counter
   a_len_nonzero : assert property (@(posedge clk) disable iff (rst)
      (phase == param_load_pkg::PHASE_IDLE && start) |->
      (weight_len != '0 && chan_len != '0));

endmodule

/* rtl/param_load_pkg.sv */
`include "param_load_config.svh"

package param_load_pkg;

   // load phases, walked in this order
   typedef enum logic [2:0] {
      PHASE_IDLE,
      PHASE_WEIGHT,
      PHASE_BIAS,
      PHASE_SCALE,
      PHASE_SHIFT
   } load_phase_e;

   // stream and table words
   typedef logic [`PL_DATA_W-1:0] data_t;

   // buffer and table addresses
   typedef logic [`PL_WEIGHT_ADDR_W-1:0] weight_addr_t;
   typedef logic [`PL_CHAN_ADDR_W-1:0] chan_addr_t;

   // lengths, one bit wider so a full buffer fits
   typedef logic [`PL_WEIGHT_ADDR_W:0] weight_count_t;
   typedef logic [`PL_CHAN_ADDR_W:0] chan_count_t;

endpackage

/* rtl/param_load_top.sv */
`timescale 1ns/1ps
`include "param_load_config.svh"

module param_load_top (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start,
   input  param_load_pkg::weight_count_t weight_len,
   input  param_load_pkg::chan_count_t   chan_len,
   input  param_load_pkg::data_t         s_data,
   input  logic                          s_valid,
   output logic                          s_ready,
   output logic                          done,
   input  param_load_pkg::weight_addr_t  weight_rd_addr,
   output param_load_pkg::data_t         weight_rd_data,
   input  param_load_pkg::chan_addr_t    chan_rd_addr,
   output param_load_pkg::data_t         bias_rd_data,
   output param_load_pkg::data_t         scale_rd_data,
   output param_load_pkg::data_t         shift_rd_data
);

   // sequencer to write stage
   logic                         beat;
   param_load_pkg::load_phase_e  phase;
   param_load_pkg::weight_addr_t index;

   // write stage to rams
   param_load_pkg::data_t        wr_data;
   param_load_pkg::weight_addr_t weight_wr_addr;
   param_load_pkg::chan_addr_t   chan_wr_addr;
   logic                         weight_we;
   logic                         bias_we;
   logic                         scale_we;
   logic                         shift_we;

   load_sequencer load_seq (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .weight_len (weight_len),
      .chan_len   (chan_len),
      .s_valid    (s_valid),
      .s_ready    (s_ready),
      .done       (done),
      .beat       (beat),
      .phase      (phase),
      .index      (index)
   );

   param_write_stage write_stage (
      .clk            (clk),
      .rst            (rst),
      .beat           (beat),
      .phase          (phase),
      .index          (index),
      .s_data         (s_data),
      .wr_data        (wr_data),
      .weight_wr_addr (weight_wr_addr),
      .chan_wr_addr   (chan_wr_addr),
      .weight_we      (weight_we),
      .bias_we        (bias_we),
      .scale_we       (scale_we),
      .shift_we       (shift_we)
   );

   // weight buffer with its own read port
   param_ram #(.ADDR_W(`PL_WEIGHT_ADDR_W), .DEPTH(`PL_WEIGHT_DEPTH)) weight_ram (
      .clk (clk), .we (weight_we), .wr_addr (weight_wr_addr), .wr_data (wr_data),
      .rd_addr (weight_rd_addr), .rd_data (weight_rd_data)
   );

   // channel tables, one shared read address
   param_ram #(.ADDR_W(`PL_CHAN_ADDR_W), .DEPTH(`PL_CHAN_DEPTH)) bias_ram (
      .clk (clk), .we (bias_we), .wr_addr (chan_wr_addr), .wr_data (wr_data),
      .rd_addr (chan_rd_addr), .rd_data (bias_rd_data)
   );

   param_ram #(.ADDR_W(`PL_CHAN_ADDR_W), .DEPTH(`PL_CHAN_DEPTH)) scale_ram (
      .clk (clk), .we (scale_we), .wr_addr (chan_wr_addr), .wr_data (wr_data),
      .rd_addr (chan_rd_addr), .rd_data (scale_rd_data)
   );

   param_ram #(.ADDR_W(`PL_CHAN_ADDR_W), .DEPTH(`PL_CHAN_DEPTH)) shift_ram (
      .clk (clk), .we (shift_we), .wr_addr (chan_wr_addr), .wr_data (wr_data),
      .rd_addr (chan_rd_addr), .rd_data (shift_rd_data)
   );

endmodule

/* rtl/param_ram.sv */
`timescale 1ns/1ps

module param_ram #(
   parameter int ADDR_W = 6,
   parameter int DEPTH  = 64
) (
   input  logic                  clk,
   input  logic                  we,
   input  logic [ADDR_W-1:0]     wr_addr,
   input  param_load_pkg::data_t wr_data,
   input  logic [ADDR_W-1:0]     rd_addr,
   output param_load_pkg::data_t rd_data
);

   // contents undefined until loaded
   param_load_pkg::data_t mem [DEPTH];

   // write port, fed from the write stage
   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, one cycle from address to data
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* rtl/param_write_stage.sv */
`timescale 1ns/1ps
`include "param_load_config.svh"

module param_write_stage (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         beat,
   input  param_load_pkg::load_phase_e  phase,
   input  param_load_pkg::weight_addr_t index,
   input  param_load_pkg::data_t        s_data,
   output param_load_pkg::data_t        wr_data,
   output param_load_pkg::weight_addr_t weight_wr_addr,
   output param_load_pkg::chan_addr_t   chan_wr_addr,
   output logic                         weight_we,
   output logic                         bias_we,
   output logic                         scale_we,
   output logic                         shift_we
);

   // data and addresses follow the beat one cycle late
   always_ff @(posedge clk) begin
      if (beat) begin
         wr_data <= s_data;
         weight_wr_addr <= index;
         // channel tables take the low index bits
         chan_wr_addr <= index[`PL_CHAN_ADDR_W-1:0];
      end
   end

   // phase decode into one enable per table
   always_ff @(posedge clk) begin
      if (rst) begin
         weight_we <= 1'b0;
         bias_we <= 1'b0;
         scale_we <= 1'b0;
         shift_we <= 1'b0;
      end else begin
         weight_we <= beat && (phase == param_load_pkg::PHASE_WEIGHT);
         bias_we <= beat && (phase == param_load_pkg::PHASE_BIAS);
         scale_we <= beat && (phase == param_load_pkg::PHASE_SCALE);
         shift_we <= beat && (phase == param_load_pkg::PHASE_SHIFT);
      end
   end

   // every beat lands in exactly one table on the next edge
   a_we_onehot : assert property (@(posedge clk) disable iff (rst)
      beat |=> $onehot({weight_we, bias_we, scale_we, shift_we}));

endmodule

/* test/param_load_tb.sv */
`timescale 1ns/1ps
`include "param_load_config.svh"

module param_load_tb;

   // bound for every handshake wait
   localparam int wait_limit = 64;

   logic                          clk = 1'b0;
   logic                          rst;
   logic                          start;
   param_load_pkg::weight_count_t weight_len;
   param_load_pkg::chan_count_t   chan_len;
   param_load_pkg::data_t         s_data;
   logic                          s_valid;
   logic                          s_ready;
   logic                          done;
   param_load_pkg::weight_addr_t  weight_rd_addr;
   param_load_pkg::data_t         weight_rd_data;
   param_load_pkg::chan_addr_t    chan_rd_addr;
   param_load_pkg::data_t         bias_rd_data;
   param_load_pkg::data_t         scale_rd_data;
   param_load_pkg::data_t         shift_rd_data;

   // model tables where beat k of a phase lands at address k
   param_load_pkg::data_t model_weight [`PL_WEIGHT_DEPTH];
   param_load_pkg::data_t model_bias [`PL_CHAN_DEPTH];
   param_load_pkg::data_t model_scale [`PL_CHAN_DEPTH];
   param_load_pkg::data_t model_shift [`PL_CHAN_DEPTH];

   int errors = 0;
   int checks = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int errors_at_test_start = 0;
   // highest lengths loaded so far set the readback range
   int hi_weight = 0;
   int hi_chan = 0;

   param_load_top uut (
      .clk            (clk),
      .rst            (rst),
      .start          (start),
      .weight_len     (weight_len),
      .chan_len       (chan_len),
      .s_data         (s_data),
      .s_valid        (s_valid),
      .s_ready        (s_ready),
      .done           (done),
      .weight_rd_addr (weight_rd_addr),
      .weight_rd_data (weight_rd_data),
      .chan_rd_addr   (chan_rd_addr),
      .bias_rd_data   (bias_rd_data),
      .scale_rd_data  (scale_rd_data),
      .shift_rd_data  (shift_rd_data)
   );

   // 20 ns period
   always #10 clk = ~clk;

   task automatic check_data(input string name, input param_load_pkg::data_t expected,
                             input param_load_pkg::data_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
      end
   endtask

   // wait for ready within a load
   task automatic wait_ready();
      int n;
      n = 0;
      while (s_ready !== 1'b1 && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (s_ready !== 1'b1) begin
         errors++;
         $display("timeout: s_ready stayed low for %0d cycles inside a load", wait_limit);
      end
   endtask

   // one full load with every beat mirrored into the model
   task automatic run_load(input int wlen, input int clen, input bit gaps, input bit poke);
      int total;
      int k;
      int j;
      int g;
      int n;
      param_load_pkg::data_t word;
      total = wlen + 3 * clen;
      check_flag("s_ready", 1'b0, s_ready);
      weight_len = param_load_pkg::weight_count_t'(wlen);
      chan_len = param_load_pkg::chan_count_t'(clen);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_flag("s_ready", 1'b1, s_ready);
      for (k = 0; k < total; k++) begin
         start = 1'b0;
         g = gaps ? int'($urandom_range(3, 0)) : 0;
         // source side idle cycles
         repeat (g) begin
            s_valid = 1'b0;
            @(negedge clk);
            check_flag("s_ready", 1'b1, s_ready);
            check_flag("done", 1'b0, done);
         end
         word = {$urandom, $urandom};
         s_data = word;
         s_valid = 1'b1;
         // stray start with odd lengths halfway through
         if (poke && k == total / 2) begin
            start = 1'b1;
            weight_len = 1;
            chan_len = 1;
         end
         // ready stays up for the whole load
         check_flag("s_ready", 1'b1, s_ready);
         wait_ready();
         check_flag("done", 1'b0, done);
         @(posedge clk);
         if (k < wlen) begin
            model_weight[k] = word;
         end else begin
            j = k - wlen;
            case (j / clen)
               0: model_bias[j % clen] = word;
               1: model_scale[j % clen] = word;
               default: model_shift[j % clen] = word;
            endcase
         end
         @(negedge clk);
      end
      s_valid = 1'b0;
      start = 1'b0;
      // done is due right after the edge of the last beat
      n = 0;
      while (done !== 1'b1 && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (done !== 1'b1) begin
         errors++;
         $display("timeout: no done within %0d cycles after the last beat", wait_limit);
      end else if (n != 0) begin
         errors++;
         $display("done came %0d cycles after the last beat instead of at once", n);
      end
      check_flag("s_ready", 1'b0, s_ready);
      @(negedge clk);
      check_flag("done", 1'b0, done);
      @(negedge clk);
      if (wlen > hi_weight) begin
         hi_weight = wlen;
      end
      if (clen > hi_chan) begin
         hi_chan = clen;
      end
   endtask

   // read data is checked one edge after the address
   task automatic read_tables(input int wn, input int cn);
      int a;
      for (a = 0; a < wn; a++) begin
         weight_rd_addr = param_load_pkg::weight_addr_t'(a);
         @(negedge clk);
         check_data("weight_rd_data", model_weight[a], weight_rd_data);
      end
      for (a = 0; a < cn; a++) begin
         chan_rd_addr = param_load_pkg::chan_addr_t'(a);
         @(negedge clk);
         check_data("bias_rd_data", model_bias[a], bias_rd_data);
         check_data("scale_rd_data", model_scale[a], scale_rd_data);
         check_data("shift_rd_data", model_shift[a], shift_rd_data);
         if (bias_rd_data == scale_rd_data || scale_rd_data == shift_rd_data ||
             bias_rd_data == shift_rd_data) begin
            errors++;
            $display("channel tables hold the same word at address %0d", a);
         end
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != errors_at_test_start) begin
         tests_failed++;
         $display("test %s: FAIL with %0d errors", name, errors - errors_at_test_start);
      end else begin
         $display("test %s: ok", name);
      end
      errors_at_test_start = errors;
   endtask

   initial begin
      int wlen;
      int clen;
      void'($urandom(53));
      rst = 1'b1;
      start = 1'b0;
      weight_len = '0;
      chan_len = '0;
      s_data = '0;
      s_valid = 1'b0;
      weight_rd_addr = '0;
      chan_rd_addr = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_flag("s_ready", 1'b0, s_ready);
      check_flag("done", 1'b0, done);
      finish_test("reset");

      // back to back beats
      wlen = $urandom_range(1024, 512);
      clen = $urandom_range(64, 32);
      run_load(wlen, clen, 1'b0, 1'b0);
      read_tables(hi_weight, hi_chan);
      finish_test("full load");

      // random valid gaps
      wlen = $urandom_range(1024, 512);
      clen = $urandom_range(64, 32);
      run_load(wlen, clen, 1'b1, 1'b0);
      read_tables(hi_weight, hi_chan);
      finish_test("gapped load");

      // shorter reload keeps the upper entries
      wlen = $urandom_range(wlen - 1, 1);
      clen = $urandom_range(clen - 1, 1);
      run_load(wlen, clen, 1'b1, 1'b1);
      read_tables(hi_weight, hi_chan);
      finish_test("reload with stray start");

      $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
